//--- bench/lcd_trace.txt
// header: init options word, number of sends, number of expected pin writes
// then sends and expected writes, one hex word each: bit 8 = rs, bits 7:0 = code
5A 40 48
// sends: display control, then 17 characters on line 0
00C
141 142 143 144 145 146 147 148 149 14A 14B 14C 14D 14E 14F 150 151
// 16 characters, the last one lands past the end of line 1
161 162 163 164 165 166 167 168 169 16A 16B 16C 16D 16E 16F 170
// clear display, then a full line of 16
001
130 131 132 133 134 135 136 137 138 139 13A 13B 13C 13D 13E 13F
// set DDRAM line 1 column 5, then 12 characters
0C5
161 162 163 164 165 166 167 168 169 16A 16B 16C
// expected: wake-up, function set, display control, clear, entry mode
030 038 00E 001 006
// display control passes through
00C
// line 0 fills, wrap to line 1 ahead of the 17th character
141 142 143 144 145 146 147 148 149 14A 14B 14C 14D 14E 14F 150
0C0 151
// line 1 fills, wrap back to line 0
161 162 163 164 165 166 167 168 169 16A 16B 16C 16D 16E 16F
080 170
// clear resets the column, no wrap for 16 characters
001
130 131 132 133 134 135 136 137 138 139 13A 13B 13C 13D 13E 13F
// column 5 on line 1, wrap before the 12th character
0C5
161 162 163 164 165 166 167 168 169 16A 16B
080 16C

//--- tb.f
+incdir+hdl
hdl/lcd_pkg.sv
hdl/lcd_cmd_queue.sv
hdl/lcd_line_wrap.sv
hdl/lcd_bus_timing.sv
hdl/lcd_ctrl_top.sv
bench/lcd_ctrl_assertions.sv
bench/lcd_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=lcd_ctrl_sim

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module lcd_ctrl_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "test passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

//--- bench/lcd_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_ctrl_tb;

	localparam int TRACE_WORDS    = 256;
	localparam int HDR_WORDS      = 3;     // options, send count, write count
	localparam int INIT_WRITES    = 5;     // wake-up plus four init commands
	localparam int TIMEOUT_MARGIN = 500;
	localparam int DRAIN_CYCLES   = 80;    // longer than one write window

	logic                    clk;
	logic                    arst_n;
	lcd_pkg::lcd_init_opts_t init_opts;
	logic                    in_valid;
	lcd_pkg::lcd_entry_t     in_entry;
	logic                    credit_return;
	logic                    busy;
	logic                    lcd_e;
	logic                    lcd_rs;
	logic                    lcd_rw;
	lcd_pkg::lcd_byte_t      lcd_data;

	logic [11:0] trace_mem [TRACE_WORDS];
	int          n_send;
	int          n_exp;
	int          limit;
	int          cycles;
	int          sent;
	int          returned;
	int          writes;
	int          errors;
	logic        e_last;

	lcd_ctrl_top i_lcd_ctrl_top (
		.clk           (clk),
		.arst_n        (arst_n),
		.init_opts     (init_opts),
		.in_valid      (in_valid),
		.in_entry      (in_entry),
		.credit_return (credit_return),
		.busy          (busy),
		.lcd_e         (lcd_e),
		.lcd_rs        (lcd_rs),
		.lcd_rw        (lcd_rw),
		.lcd_data      (lcd_data)
	);

	always #2 clk = ~clk;

	// cycle count and returned credits
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (arst_n && credit_return) begin
			returned <= returned + 1;
			if (returned + 1 > sent) begin
				$display("credit returned without a matching send (%0d returned, %0d sent)",
					returned + 1, sent);
				errors++;
			end
		end
	end

	// compare one LCD write with the next expected one
	task automatic check_write();
		logic [11:0] w;
		logic        exp_busy;
		if (writes >= n_exp) begin
			$display("unexpected extra LCD write %0d: rs %h data %h", writes, lcd_rs, lcd_data);
			errors++;
		end else begin
			w        = trace_mem[HDR_WORDS + n_send + writes];
			exp_busy = (writes < INIT_WRITES);    // init pulses come while busy
			if (lcd_rs !== w[8]) begin
				$display("[ERROR] write %0d lcd_rs: expected %h, got %h", writes, w[8], lcd_rs);
				errors++;
			end
			if (lcd_data !== w[7:0]) begin
				$display("[ERROR] write %0d lcd_data: expected %h, got %h",
					writes, w[7:0], lcd_data);
				errors++;
			end
			if (busy !== exp_busy) begin
				$display("[ERROR] write %0d busy: expected %h, got %h", writes, exp_busy, busy);
				errors++;
			end
		end
		writes++;
	endtask

	// pin monitor samples the enable edge mid-cycle
	always @(negedge clk) begin
		if (arst_n && lcd_e && !e_last) begin
			check_write();
		end
		e_last = lcd_e;
	end

	initial begin
		int gap;
		int idx;
		void'($urandom(32'h8ca9a2df));
		clk       = 1'b0;
		arst_n    = 1'b0;
		init_opts = '0;
		in_valid  = 1'b0;
		in_entry  = '0;
		cycles    = 0;
		sent      = 0;
		returned  = 0;
		writes    = 0;
		errors    = 0;
		e_last    = 1'b0;
		n_send    = 0;
		n_exp     = 0;

		$readmemh("bench/lcd_trace.txt", trace_mem);
		if (!$isunknown(trace_mem[1]) && !$isunknown(trace_mem[2])) begin
			n_send = int'(trace_mem[1]);
			n_exp  = int'(trace_mem[2]);
		end
		limit = 1000 + 60 * n_exp + TIMEOUT_MARGIN;

		if (n_send == 0 || n_exp == 0 || HDR_WORDS + n_send + n_exp > TRACE_WORDS) begin
			$display("trace file is missing or its header is malformed");
			errors++;
		end else begin
			init_opts = trace_mem[0][6:0];
			repeat (16) @(negedge clk);
			arst_n = 1'b1;

			// producer sends one entry per credit with random idle gaps
			idx = 0;
			gap = int'($urandom % 4);
			while (idx < n_send && cycles < limit) begin
				@(negedge clk);
				if (gap > 0) begin
					in_valid = 1'b0;
					gap--;
				end else if (`LCD_QUEUE_DEPTH + returned - sent > 0) begin
					in_valid = 1'b1;
					in_entry = trace_mem[HDR_WORDS + idx][8:0];
					sent++;
					idx++;
					gap = int'($urandom % 4);
				end else begin
					in_valid = 1'b0;       // out of credits for now
				end
			end
			@(negedge clk);
			in_valid = 1'b0;

			while (writes < n_exp && cycles < limit) begin
				@(posedge clk);
			end

			if (writes < n_exp) begin
				$display("timeout after %0d cycles: only %0d of %0d expected LCD writes appeared",
					cycles, writes, n_exp);
				errors++;
			end else begin
				repeat (DRAIN_CYCLES) @(posedge clk);
				if (busy !== 1'b0) begin
					$display("[ERROR] busy: expected %h, got %h", 1'b0, busy);
					errors++;
				end
				if (returned != sent) begin
					$display("credits do not balance: %0d sent, %0d returned", sent, returned);
					errors++;
				end
			end
		end

		$display("errors: %0d, LCD writes: %0d of %0d", errors, writes, n_exp);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/lcd_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_ctrl_assertions (
	input wire logic                                    clk,
	input wire logic                                    arst_n,
	input wire logic                                    in_valid,
	input wire logic [$clog2(`LCD_QUEUE_DEPTH + 1)-1:0] q_count,
	input wire logic                                    lcd_e,
	input wire logic                                    lcd_rs,
	input wire logic                                    lcd_rw,
	input wire lcd_pkg::lcd_byte_t                      lcd_data
);

	localparam int unsigned CNT_W = $clog2(`LCD_QUEUE_DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(`LCD_QUEUE_DEPTH);

	// a send needs a free slot
	no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> (q_count != FULL))
		else $error("queue overflow, entry sent with %0d entries queued", q_count);

	rw_low: assert property (@(posedge clk) disable iff (!arst_n)
		lcd_rw == 1'b0)
		else $error("lcd_rw driven high");

	// bus held while enable is high
	pins_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(lcd_e && $past(lcd_e)) |-> ($stable(lcd_data) && $stable(lcd_rs)))
		else $error("lcd_data or lcd_rs changed while lcd_e was high");

endmodule

bind lcd_ctrl_top lcd_ctrl_assertions i_lcd_ctrl_assertions (
	.clk      (clk),
	.arst_n   (arst_n),
	.in_valid (in_valid),
	.q_count  (i_lcd_cmd_queue.count),
	.lcd_e    (lcd_e),
	.lcd_rs   (lcd_rs),
	.lcd_rw   (lcd_rw),
	.lcd_data (lcd_data)
);

`default_nettype wire

//--- hdl/lcd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire lcd_pkg::lcd_init_opts_t init_opts,
	input  wire logic                    in_valid,
	input  wire lcd_pkg::lcd_entry_t     in_entry,
	output logic                         credit_return,
	output logic                         busy,
	output logic                         lcd_e,
	output logic                         lcd_rs,
	output logic                         lcd_rw,
	output lcd_pkg::lcd_byte_t           lcd_data
);

	logic                q_valid;      // queue head
	logic                q_accept;
	lcd_pkg::lcd_entry_t q_entry;
	logic                w_valid;      // wrap stage output
	logic                w_accept;
	lcd_pkg::lcd_entry_t w_entry;

	lcd_cmd_queue i_lcd_cmd_queue (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_entry      (in_entry),
		.out_accept    (q_accept),
		.credit_return (credit_return),
		.out_valid     (q_valid),
		.out_entry     (q_entry)
	);

	lcd_line_wrap i_lcd_line_wrap (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (q_valid),
		.in_entry   (q_entry),
		.out_accept (w_accept),
		.in_accept  (q_accept),
		.out_valid  (w_valid),
		.out_entry  (w_entry)
	);

	lcd_bus_timing i_lcd_bus_timing (
		.clk       (clk),
		.arst_n    (arst_n),
		.init_opts (init_opts),
		.in_valid  (w_valid),
		.in_entry  (w_entry),
		.in_accept (w_accept),
		.busy      (busy),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data)
	);

endmodule

`default_nettype wire

//--- hdl/lcd_bus_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_bus_timing (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire lcd_pkg::lcd_init_opts_t init_opts,
	input  wire logic                    in_valid,
	input  wire lcd_pkg::lcd_entry_t     in_entry,
	output logic                         in_accept,
	output logic                         busy,
	output logic                         lcd_e,
	output logic                         lcd_rs,
	output logic                         lcd_rw,
	output lcd_pkg::lcd_byte_t           lcd_data
);

	localparam int unsigned CYC = `LCD_CLK_PER_US;
	localparam int unsigned INIT_E_US = 10;    // init enable pulse
	localparam int unsigned CNT_W = $clog2(`LCD_T_POWERUP * CYC + 1);

	localparam logic [CNT_W-1:0] T_POWERUP = CNT_W'(`LCD_T_POWERUP * CYC);
	localparam logic [CNT_W-1:0] T_WAKE = CNT_W'((`LCD_T_POWERUP - `LCD_T_CMD_WAIT) * CYC);
	localparam logic [CNT_W-1:0] T_E_SETUP = CNT_W'(`LCD_T_E_SETUP * CYC);
	localparam logic [CNT_W-1:0] T_INIT_E_END = CNT_W'((`LCD_T_E_SETUP + INIT_E_US) * CYC);
	localparam logic [CNT_W-1:0] T_E_END = CNT_W'((`LCD_T_E_SETUP + `LCD_T_E_HIGH) * CYC);
	localparam logic [CNT_W-1:0] T_WRITE = CNT_W'(`LCD_T_WRITE * CYC);

	lcd_pkg::lcd_phase_e phase;
	logic [CNT_W-1:0]    cnt;
	logic [1:0]          step;        // init command index
	logic [CNT_W-1:0]    step_end;
	lcd_pkg::lcd_byte_t  init_word;
	lcd_pkg::lcd_entry_t entry_q;
	logic                e_d;
	logic                rs_d;
	lcd_pkg::lcd_byte_t  data_d;

	assign in_accept = (phase == lcd_pkg::IDLE);
	assign lcd_rw    = 1'b0;               // write only

	always_comb begin
		case (step)
			2'd0: begin                        // function set
				init_word = {4'b0011, init_opts.two_line, init_opts.font_5x10, 2'b00};
				step_end  = CNT_W'((INIT_E_US + `LCD_T_CMD_WAIT) * CYC - 1);
			end
			2'd1: begin                        // display control
				init_word = {5'b00001, init_opts.display_on, init_opts.cursor_on,
					init_opts.blink};
				step_end  = CNT_W'((INIT_E_US + `LCD_T_CMD_WAIT) * CYC - 1);
			end
			2'd2: begin                        // clear display
				init_word = 8'h01;
				step_end  = CNT_W'((INIT_E_US + `LCD_T_CLEAR_WAIT) * CYC - 1);
			end
			default: begin                     // entry mode set
				init_word = {6'b000001, init_opts.increment, init_opts.shift};
				step_end  = CNT_W'((INIT_E_US + `LCD_T_ENTRY_WAIT) * CYC - 1);
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= lcd_pkg::POWERUP;
			cnt   <= '0;
			step  <= '0;
		end else begin
			case (phase)
				lcd_pkg::POWERUP: begin
					if (cnt == T_POWERUP - 1'b1) begin
						phase <= lcd_pkg::INIT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				lcd_pkg::INIT: begin
					if (cnt == step_end) begin
						cnt  <= '0;
						step <= step + 1'b1;
						if (step == 2'd3) begin
							phase <= lcd_pkg::IDLE;  // init complete
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				lcd_pkg::IDLE: begin
					if (in_valid) begin
						phase <= lcd_pkg::WRITE;
						cnt   <= '0;
					end
				end
				default: begin
					if (cnt == T_WRITE) begin
						phase <= lcd_pkg::IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_accept) begin
			entry_q <= in_entry;
		end
	end

	// pin values for the current phase and count
	always_comb begin
		e_d    = 1'b0;
		rs_d   = 1'b0;
		data_d = '0;
		case (phase)
			lcd_pkg::POWERUP: begin
				if (cnt >= T_WAKE) begin
					data_d = 8'h30;            // wake-up write
					e_d    = (cnt >= T_WAKE + T_E_SETUP) && (cnt < T_WAKE + T_INIT_E_END);
				end
			end
			lcd_pkg::INIT: begin
				data_d = init_word;
				e_d    = (cnt >= T_E_SETUP) && (cnt < T_INIT_E_END);
			end
			lcd_pkg::WRITE: begin
				rs_d   = entry_q.rs;
				data_d = entry_q.code;
				e_d    = (cnt >= T_E_SETUP) && (cnt < T_E_END);
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;
		end else begin
			lcd_e    <= e_d;
			lcd_rs   <= rs_d;
			lcd_data <= data_d;
			busy     <= (phase == lcd_pkg::POWERUP) || (phase == lcd_pkg::INIT);
		end
	end

endmodule

`default_nettype wire

//--- hdl/lcd_line_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_line_wrap (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire logic                in_valid,
	input  wire lcd_pkg::lcd_entry_t in_entry,
	input  wire logic                out_accept,
	output logic                     in_accept,
	output logic                     out_valid,
	output lcd_pkg::lcd_entry_t      out_entry
);

	localparam lcd_pkg::lcd_col_t LINE_END = 5'd16;
	localparam lcd_pkg::lcd_byte_t ADDR_LINE0 = 8'h80;
	localparam lcd_pkg::lcd_byte_t ADDR_LINE1 = 8'hC0;

	lcd_pkg::lcd_entry_t held;
	logic                held_valid;
	logic                line;        // cursor line
	lcd_pkg::lcd_col_t   col;         // cursor column
	logic                need_wrap;
	logic                out_fire;
	logic                is_home;

	assign in_accept = !held_valid;
	assign out_valid = held_valid;
	assign out_fire  = out_valid && out_accept;

	// character would land past column 15
	assign need_wrap = held.rs && (col == LINE_END);

	// clear display or return home
	assign is_home = !held.rs && ((held.code == 8'h01) || (held.code[7:1] == 7'h01));

	always_comb begin
		out_entry = held;
		if (need_wrap) begin
			out_entry.rs   = 1'b0;
			out_entry.code = line ? ADDR_LINE0 : ADDR_LINE1;  // jump to the other line
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_accept) begin
			held <= in_entry;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held_valid <= 1'b0;
			line       <= 1'b0;
			col        <= '0;
		end else begin
			if (in_valid && in_accept) begin
				held_valid <= 1'b1;
			end else if (out_fire && !need_wrap) begin
				held_valid <= 1'b0;            // character stays through the injected command
			end

			if (out_fire) begin
				if (need_wrap) begin
					line <= !line;
					col  <= '0;
				end else if (held.rs) begin
					col <= col + 1'b1;
				end else if (held.code[7]) begin
					// set DDRAM address
					line <= held.code[6];
					col  <= {1'b0, held.code[3:0]};
				end else if (is_home) begin
					line <= 1'b0;
					col  <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/lcd_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_cmd_queue (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire logic                in_valid,
	input  wire lcd_pkg::lcd_entry_t in_entry,
	input  wire logic                out_accept,
	output logic                     credit_return,
	output logic                     out_valid,
	output lcd_pkg::lcd_entry_t      out_entry
);

	localparam int unsigned DEPTH = `LCD_QUEUE_DEPTH;
	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

	lcd_pkg::lcd_entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign push      = in_valid;               // producer holds a credit
	assign pop       = out_valid && out_accept;
	assign out_valid = (count != '0);
	assign out_entry = mem[rd_ptr];            // head entry

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_entry;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;              // one credit per taken entry
			if (push) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;       // none or both
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// value on the 8-bit LCD data bus
	typedef logic [7:0] lcd_byte_t;

	// cursor column, 0 to 16
	typedef logic [4:0] lcd_col_t;

	// one write to the LCD
	typedef struct packed {
		logic      rs;    // 1 data, 0 instruction
		lcd_byte_t code;
	} lcd_entry_t;

	// init options word with two_line as msb
	typedef struct packed {
		logic two_line;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink;
		logic increment;
		logic shift;
	} lcd_init_opts_t;

	// bus timing stage phases
	typedef enum logic [1:0] {
		POWERUP,   // power-up wait and wake-up write
		INIT,      // init command sequence
		IDLE,      // ready for an entry
		WRITE      // write window of one entry
	} lcd_phase_e;

endpackage

`default_nettype wire

//--- hdl/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// clock cycles per microsecond
`define LCD_CLK_PER_US 1

// queue entries and producer credits
`define LCD_QUEUE_DEPTH 4

// LCD delays in microseconds
`define LCD_T_POWERUP 500     // wait after power on
`define LCD_T_CMD_WAIT 50     // after function set and display control
`define LCD_T_CLEAR_WAIT 200  // after clear display
`define LCD_T_ENTRY_WAIT 100  // after entry mode set
`define LCD_T_WRITE 50        // whole write window
`define LCD_T_E_SETUP 1       // rs and data ahead of enable
`define LCD_T_E_HIGH 13       // enable high time

`endif
